// ==== test/l1d_golden.txt ====
# Columns: op (R or W), byte address, write data, expected read data, hit mark
# Hit mark: H must hit, M must miss, - either; all values in hex
R 00000010 00000000 a5a50010 M
R 00000014 00000000 a5a50014 H
W 00000018 11112222 00000000 H
R 00000018 00000000 11112222 H
W 00000004 cafe0004 00000000 M
R 00000000 00000000 a5a50000 H
R 0000000c 00000000 a5a5000c H
W 00000088 0bad0088 00000000 M
R 00000104 00000000 a5a50104 M
R 00000004 00000000 cafe0004 -
R 00000088 00000000 0bad0088 -
R 00000080 00000000 a5a50080 -
W 00000234 77778888 00000000 M
R 00000230 00000000 a5a50230 H
R 00000234 00000000 77778888 H
R 00000434 00000000 a5a50434 M
R 00000634 00000000 a5a50634 M
R 00000234 00000000 77778888 -
R 00000018 00000000 11112222 -

// ==== l1d_cache.f ====
source/l1d_geom_pkg.sv
source/l1d_policy_pkg.sv
source/l1d_tag_store.sv
source/l1d_data_store.sv
source/l1d_mem_port.sv
source/l1d_ctrl.sv
source/l1d_cache.sv
test/l1d_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" \
    && rm -f sim.log \
    && verilator --binary --timing --assert --top-module l1d_cache_tb -f l1d_cache.f -o l1d_sim \
    && { ./obj_dir/l1d_sim > sim.log 2>&1; cat sim.log; } \
    && ! grep -q "Simulation finished: FAIL" sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

// ==== test/l1d_cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1d_cache_tb;

    localparam int SLOT_W           = 8;
    localparam int MEM_LINES        = 1 << SLOT_W;
    localparam int CYCLES_PER_ENTRY = 300;
    localparam int HIT_CYCLES       = 2;
    localparam int MEM_READ_WAIT    = 2;

    logic                            clk_i;
    logic                            rstn_i;
    logic                            req_valid_i;
    logic                            req_ready_o;
    logic                            req_write_i;
    logic [l1d_geom_pkg::ADDR_W-1:0] req_addr_i;
    logic [l1d_geom_pkg::DATA_W-1:0] req_wdata_i;
    logic                            resp_valid_o;
    logic                            resp_ready_i;
    logic [l1d_geom_pkg::DATA_W-1:0] resp_rdata_o;
    logic                            mem_req_valid_o;
    logic                            mem_req_ready_i;
    logic                            mem_req_write_o;
    logic [l1d_geom_pkg::ADDR_W-1:0] mem_req_addr_o;
    l1d_geom_pkg::line_u             mem_req_wdata_o;
    logic                            mem_resp_valid_i;
    logic                            mem_resp_ready_o;
    l1d_geom_pkg::line_u             mem_resp_rdata_i;

    // Backing memory and the image it should hold once every write is merged
    l1d_geom_pkg::line_u mem_lines [MEM_LINES];
    l1d_geom_pkg::line_u ref_lines [MEM_LINES];

    logic [15:0]                     lfsr;
    int                              cycles;
    int                              cycle_limit;
    int                              mem_reqs;
    int                              wb_count;
    logic                            rd_pending;
    logic                            rd_served;
    logic [l1d_geom_pkg::ADDR_W-1:0] rd_addr;
    int                              rd_wait;
    logic                            prev_resp_valid;
    logic                            prev_resp_ready;
    logic [l1d_geom_pkg::DATA_W-1:0] prev_rdata;
    logic                            resp_taken;
    logic [l1d_geom_pkg::DATA_W-1:0] resp_word;

    logic [7:0]                      ops [$];
    logic [l1d_geom_pkg::ADDR_W-1:0] addrs [$];
    logic [l1d_geom_pkg::DATA_W-1:0] wdatas [$];
    logic [l1d_geom_pkg::DATA_W-1:0] exp_words [$];
    logic [7:0]                      hit_marks [$];

    l1d_cache dut0 (.*);

    always #2 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_word(input string name, input logic [l1d_geom_pkg::DATA_W-1:0] got,
                              input logic [l1d_geom_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_line(input string name, input l1d_geom_pkg::line_u got,
                              input l1d_geom_pkg::line_u exp);
        if (got.flat !== exp.flat) begin
            abort_run($sformatf("** Error: %s expected %h got %h", name, exp.flat, got.flat));
        end
    endtask

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic next_bit(output logic b);
        b    = lfsr[0];
        lfsr = galois_step(lfsr);
    endtask

    function automatic logic [SLOT_W-1:0] line_slot(input logic [l1d_geom_pkg::ADDR_W-1:0] a);
        return a[l1d_geom_pkg::OFFSET_W +: SLOT_W];
    endfunction

    task automatic accept_mem_req();
        if ((mem_req_addr_o >> (l1d_geom_pkg::OFFSET_W + SLOT_W)) != 0) begin
            abort_run($sformatf("Memory request to %h is outside the model", mem_req_addr_o));
        end else begin
            mem_reqs++;
            if (mem_req_write_o) begin
                check_line("mem_req_wdata_o", mem_req_wdata_o,
                           ref_lines[line_slot(mem_req_addr_o)]);
                mem_lines[line_slot(mem_req_addr_o)] = mem_req_wdata_o;
                wb_count++;
            end else begin
                rd_pending = 1'b1;
                rd_addr    = mem_req_addr_o;
                rd_wait    = MEM_READ_WAIT;
            end
        end
    endtask

    // Sample outputs once per clock, then drive stalls and the memory model
    task automatic tick();
        logic b;
        @(posedge clk_i);
        #1;
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
        end
        if (prev_resp_valid && !prev_resp_ready) begin
            check_bit("resp_valid_o", resp_valid_o, 1'b1);
            check_word("resp_rdata_o", resp_rdata_o, prev_rdata);
        end
        next_bit(b);
        resp_ready_i = b;
        if (resp_valid_o && resp_ready_i) begin
            resp_taken = 1'b1;
            resp_word  = resp_rdata_o;
        end
        prev_resp_valid = resp_valid_o;
        prev_resp_ready = resp_ready_i;
        prev_rdata      = resp_rdata_o;

        if (rd_served) begin
            mem_resp_valid_i = 1'b0;
            rd_served        = 1'b0;
        end
        next_bit(b);
        mem_req_ready_i = b;
        if (mem_req_valid_o && mem_req_ready_i) begin
            accept_mem_req();
        end
        // Response valid is held once raised
        if (rd_pending && !mem_resp_valid_i) begin
            if (rd_wait > 0) begin
                rd_wait--;
            end else begin
                next_bit(b);
                if (b) begin
                    mem_resp_valid_i = 1'b1;
                    mem_resp_rdata_i = mem_lines[line_slot(rd_addr)];
                end
            end
        end
        if (mem_resp_valid_i && mem_resp_ready_o) begin
            rd_pending = 1'b0;
            rd_served  = 1'b1;
        end
    endtask

    task automatic run_entry(input int i);
        int                              lat;
        int                              reqs_before;
        logic                            is_write;
        logic [l1d_geom_pkg::WORD_SEL_W-1:0] sel;
        is_write = (ops[i] == "W");
        sel      = addrs[i][l1d_geom_pkg::WORD_SEL_LSB +: l1d_geom_pkg::WORD_SEL_W];
        while (!req_ready_o) begin
            tick();
        end
        req_valid_i = 1'b1;
        req_write_i = is_write;
        req_addr_i  = addrs[i];
        req_wdata_i = wdatas[i];
        if (is_write) begin
            ref_lines[line_slot(addrs[i])].words[sel] = wdatas[i];
        end
        reqs_before = mem_reqs;
        resp_taken  = 1'b0;
        tick();
        req_valid_i = 1'b0;
        lat         = 1;
        if (is_write) begin
            while (!req_ready_o) begin
                tick();
                lat++;
            end
        end else begin
            while (!resp_valid_o) begin
                tick();
                lat++;
            end
            while (!resp_taken) begin
                tick();
            end
            check_word("resp_rdata_o", resp_word, exp_words[i]);
        end
        if (hit_marks[i] == "H" && (lat != HIT_CYCLES || mem_reqs != reqs_before)) begin
            abort_run($sformatf("Entry %0d at %h should hit but took %0d cycles and %0d requests",
                                i, addrs[i], lat, mem_reqs - reqs_before));
        end else if (hit_marks[i] == "M" && mem_reqs == reqs_before) begin
            abort_run($sformatf("Entry %0d at %h should miss but reached no memory", i, addrs[i]));
        end
    endtask

    initial begin
        int                              fd;
        int                              n;
        string                           text;
        logic [7:0]                      op_c;
        logic [7:0]                      hit_c;
        logic [l1d_geom_pkg::ADDR_W-1:0] a;
        logic [l1d_geom_pkg::DATA_W-1:0] d;
        logic [l1d_geom_pkg::DATA_W-1:0] e;
        clk_i            = 1'b0;
        rstn_i           = 1'b0;
        req_valid_i      = 1'b0;
        req_write_i      = 1'b0;
        req_addr_i       = '0;
        req_wdata_i      = '0;
        resp_ready_i     = 1'b0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_rdata_i = '0;
        lfsr             = 16'd66;
        cycles           = 0;
        mem_reqs         = 0;
        wb_count         = 0;
        rd_pending       = 1'b0;
        rd_served        = 1'b0;
        rd_addr          = '0;
        rd_wait          = 0;
        prev_resp_valid  = 1'b0;
        prev_resp_ready  = 1'b0;
        prev_rdata       = '0;
        resp_taken       = 1'b0;
        resp_word        = '0;

        // Every word starts as its own byte address XOR a5a50000
        for (int i = 0; i < MEM_LINES; i++) begin
            for (int k = 0; k < l1d_geom_pkg::WORDS_PER_LINE; k++) begin
                mem_lines[i].words[k] = l1d_geom_pkg::DATA_W'((i << l1d_geom_pkg::OFFSET_W)
                    + (k << l1d_geom_pkg::WORD_SEL_LSB)) ^ 32'hA5A5_0000;
            end
            ref_lines[i] = mem_lines[i];
        end

        fd = $fopen("test/l1d_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the golden file test/l1d_golden.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            n    = $fgets(text, fd);
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            n = $sscanf(text, "%c %h %h %h %c", op_c, a, d, e, hit_c);
            if (n != 5) begin
                abort_run($sformatf("Malformed golden line: %s", text));
            end
            ops.push_back(op_c);
            addrs.push_back(a);
            wdatas.push_back(d);
            exp_words.push_back(e);
            hit_marks.push_back(hit_c);
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            abort_run("The golden file holds no operations");
        end
        cycle_limit = CYCLES_PER_ENTRY * ops.size() + 20;

        repeat (3) begin
            tick();
        end
        rstn_i = 1'b1;
        tick();
        check_bit("req_ready_o", req_ready_o, 1'b1);
        check_bit("resp_valid_o", resp_valid_o, 1'b0);
        check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
        check_bit("mem_resp_ready_o", mem_resp_ready_o, 1'b0);

        for (int i = 0; i < ops.size(); i++) begin
            run_entry(i);
        end

        if (wb_count == 0) begin
            abort_run("No dirty line was ever written back to memory");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/l1d_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1d_cache (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire logic                              req_valid_i,
    output logic                                   req_ready_o,
    input  wire logic                              req_write_i,
    input  wire logic [l1d_geom_pkg::ADDR_W-1:0]   req_addr_i,
    input  wire logic [l1d_geom_pkg::DATA_W-1:0]   req_wdata_i,
    output logic                                   resp_valid_o,
    input  wire logic                              resp_ready_i,
    output logic [l1d_geom_pkg::DATA_W-1:0]        resp_rdata_o,
    output logic                                   mem_req_valid_o,
    input  wire logic                              mem_req_ready_i,
    output logic                                   mem_req_write_o,
    output logic [l1d_geom_pkg::ADDR_W-1:0]        mem_req_addr_o,
    output l1d_geom_pkg::line_u                    mem_req_wdata_o,
    input  wire logic                              mem_resp_valid_i,
    output logic                                   mem_resp_ready_o,
    input  wire l1d_geom_pkg::line_u               mem_resp_rdata_i
);

    logic                             hit;
    logic [l1d_policy_pkg::WAY_W-1:0] hit_way;
    logic [l1d_policy_pkg::WAY_W-1:0] victim_way;
    logic                             victim_dirty;
    logic [l1d_geom_pkg::TAG_W-1:0]   victim_tag;
    logic [l1d_geom_pkg::ADDR_W-1:0]  lookup_addr;
    logic                             tag_fill;
    logic [l1d_policy_pkg::WAY_W-1:0] tag_fill_way;
    logic                             mark_dirty;
    logic [l1d_geom_pkg::DATA_W-1:0]  rd_word;
    l1d_geom_pkg::line_u              victim_line;
    logic                             word_we;
    logic                             line_we;
    logic [l1d_policy_pkg::WAY_W-1:0] way;
    logic [l1d_geom_pkg::DATA_W-1:0]  wdata;
    logic                             mem_done;
    l1d_geom_pkg::line_u              mem_fill_line;
    logic                             mem_start;
    logic                             mem_write;
    logic [l1d_geom_pkg::ADDR_W-1:0]  mem_addr;
    l1d_geom_pkg::line_u              ctrl_line;

    l1d_ctrl ctrl0 (
        .clk_i, .rstn_i, .req_valid_i, .req_write_i, .req_addr_i, .req_wdata_i,
        .resp_ready_i, .req_ready_o, .resp_valid_o, .resp_rdata_o,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
        .lookup_addr_o(lookup_addr), .tag_fill_o(tag_fill), .tag_fill_way_o(tag_fill_way),
        .mark_dirty_o(mark_dirty), .rd_word_i(rd_word), .victim_line_i(victim_line),
        .word_we_o(word_we), .line_we_o(line_we), .way_o(way), .wdata_o(wdata),
        .mem_done_i(mem_done), .fill_line_i(mem_fill_line), .mem_start_o(mem_start),
        .mem_write_o(mem_write), .mem_addr_o(mem_addr), .fill_line_o(ctrl_line)
    );

    l1d_tag_store tags0 (
        .clk_i, .rstn_i, .lookup_addr_i(lookup_addr), .fill_i(tag_fill),
        .fill_way_i(tag_fill_way), .mark_dirty_i(mark_dirty), .dirty_way_i(way),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
    );

    l1d_data_store data0 (
        .clk_i,
        .index_i(lookup_addr[l1d_geom_pkg::INDEX_LSB +: l1d_geom_pkg::INDEX_W]),
        .word_sel_i(lookup_addr[l1d_geom_pkg::WORD_SEL_LSB +: l1d_geom_pkg::WORD_SEL_W]),
        .way_i(way), .word_we_i(word_we), .wdata_i(wdata), .line_we_i(line_we),
        .line_i(ctrl_line), .rd_word_o(rd_word), .line_o(victim_line)
    );

    l1d_mem_port mem0 (
        .clk_i, .rstn_i, .start_i(mem_start), .write_i(mem_write), .addr_i(mem_addr),
        .line_i(ctrl_line), .mem_req_ready_i, .mem_resp_valid_i, .mem_resp_rdata_i,
        .done_o(mem_done), .fill_line_o(mem_fill_line), .mem_req_valid_o,
        .mem_req_write_o, .mem_req_addr_o, .mem_req_wdata_o, .mem_resp_ready_o
    );

endmodule

`default_nettype wire

// ==== source/l1d_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1d_ctrl (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire logic                              req_valid_i,
    input  wire logic                              req_write_i,
    input  wire logic [l1d_geom_pkg::ADDR_W-1:0]   req_addr_i,
    input  wire logic [l1d_geom_pkg::DATA_W-1:0]   req_wdata_i,
    input  wire logic                              resp_ready_i,
    output logic                                   req_ready_o,
    output logic                                   resp_valid_o,
    output logic [l1d_geom_pkg::DATA_W-1:0]        resp_rdata_o,

    input  wire logic                              hit_i,
    input  wire logic [l1d_policy_pkg::WAY_W-1:0]  hit_way_i,
    input  wire logic [l1d_policy_pkg::WAY_W-1:0]  victim_way_i,
    input  wire logic                              victim_dirty_i,
    input  wire logic [l1d_geom_pkg::TAG_W-1:0]    victim_tag_i,
    output logic [l1d_geom_pkg::ADDR_W-1:0]        lookup_addr_o,
    output logic                                   tag_fill_o,
    output logic [l1d_policy_pkg::WAY_W-1:0]       tag_fill_way_o,
    output logic                                   mark_dirty_o,

    input  wire logic [l1d_geom_pkg::DATA_W-1:0]   rd_word_i,
    input  wire l1d_geom_pkg::line_u               victim_line_i,
    output logic                                   word_we_o,
    output logic                                   line_we_o,
    output logic [l1d_policy_pkg::WAY_W-1:0]       way_o,
    output logic [l1d_geom_pkg::DATA_W-1:0]        wdata_o,

    input  wire logic                              mem_done_i,
    input  wire l1d_geom_pkg::line_u               fill_line_i,
    output logic                                   mem_start_o,
    output logic                                   mem_write_o,
    output logic [l1d_geom_pkg::ADDR_W-1:0]        mem_addr_o,
    output l1d_geom_pkg::line_u                    fill_line_o
);

    logic [l1d_policy_pkg::ST_W-1:0]  state_q;
    logic [l1d_policy_pkg::ST_W-1:0]  state_d;
    logic [l1d_geom_pkg::ADDR_W-1:0]  addr_q;
    logic                             write_q;
    logic [l1d_geom_pkg::DATA_W-1:0]  wdata_q;
    logic [l1d_geom_pkg::DATA_W-1:0]  rdata_q;
    logic [l1d_geom_pkg::INDEX_W-1:0] index;
    logic                             lookup_hit;
    logic                             evict;

    assign index      = addr_q[l1d_geom_pkg::INDEX_LSB +: l1d_geom_pkg::INDEX_W];
    assign lookup_hit = (state_q == l1d_policy_pkg::ST_LOOKUP) && hit_i;
    assign evict      = (state_q == l1d_policy_pkg::ST_LOOKUP) && !hit_i && victim_dirty_i;

    assign req_ready_o  = state_q == l1d_policy_pkg::ST_IDLE;
    assign resp_valid_o = state_q == l1d_policy_pkg::ST_RESPOND;
    assign resp_rdata_o = rdata_q;

    assign lookup_addr_o = addr_q;
    assign word_we_o     = lookup_hit && write_q;
    assign mark_dirty_o  = lookup_hit && write_q;
    assign wdata_o       = wdata_q;
    assign way_o         = lookup_hit ? hit_way_i : victim_way_i;

    // Refill lands in the victim way, which stays put until the tag update
    assign line_we_o      = (state_q == l1d_policy_pkg::ST_FILL_WAIT) && mem_done_i;
    assign tag_fill_o     = line_we_o;
    assign tag_fill_way_o = victim_way_i;

    assign mem_start_o = evict || (state_q == l1d_policy_pkg::ST_FILL);
    assign mem_write_o = evict;
    assign mem_addr_o  = evict ? {victim_tag_i, index, {l1d_geom_pkg::OFFSET_W{1'b0}}}
                               : {addr_q[l1d_geom_pkg::ADDR_W-1:l1d_geom_pkg::OFFSET_W],
                                  {l1d_geom_pkg::OFFSET_W{1'b0}}};

    // Victim line goes out on eviction, refill line comes in on fill
    assign fill_line_o = (state_q == l1d_policy_pkg::ST_FILL_WAIT) ? fill_line_i : victim_line_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            l1d_policy_pkg::ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = l1d_policy_pkg::ST_LOOKUP;
                end
            end
            l1d_policy_pkg::ST_LOOKUP: begin
                if (hit_i) begin
                    state_d = write_q ? l1d_policy_pkg::ST_IDLE : l1d_policy_pkg::ST_RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = l1d_policy_pkg::ST_EVICT;
                end else begin
                    state_d = l1d_policy_pkg::ST_FILL;
                end
            end
            l1d_policy_pkg::ST_RESPOND: begin
                if (resp_ready_i) begin
                    state_d = l1d_policy_pkg::ST_IDLE;
                end
            end
            l1d_policy_pkg::ST_EVICT: begin
                if (mem_done_i) begin
                    state_d = l1d_policy_pkg::ST_FILL;
                end
            end
            l1d_policy_pkg::ST_FILL: begin
                state_d = l1d_policy_pkg::ST_FILL_WAIT;
            end
            l1d_policy_pkg::ST_FILL_WAIT: begin
                // Retry the lookup, which now hits
                if (mem_done_i) begin
                    state_d = l1d_policy_pkg::ST_LOOKUP;
                end
            end
            default: begin
                state_d = l1d_policy_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= l1d_policy_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            addr_q  <= req_addr_i;
            write_q <= req_write_i;
            wdata_q <= req_wdata_i;
        end
        if (lookup_hit && !write_q) begin
            rdata_q <= rd_word_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o));

endmodule

`default_nettype wire

// ==== source/l1d_mem_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1d_mem_port (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire logic                              start_i,
    input  wire logic                              write_i,
    input  wire logic [l1d_geom_pkg::ADDR_W-1:0]   addr_i,
    input  wire l1d_geom_pkg::line_u               line_i,
    input  wire logic                              mem_req_ready_i,
    input  wire logic                              mem_resp_valid_i,
    input  wire l1d_geom_pkg::line_u               mem_resp_rdata_i,
    output logic                                   done_o,
    output l1d_geom_pkg::line_u                    fill_line_o,
    output logic                                   mem_req_valid_o,
    output logic                                   mem_req_write_o,
    output logic [l1d_geom_pkg::ADDR_W-1:0]        mem_req_addr_o,
    output l1d_geom_pkg::line_u                    mem_req_wdata_o,
    output logic                                   mem_resp_ready_o
);

    logic                            req_valid_q;
    logic                            req_write_q;
    logic [l1d_geom_pkg::ADDR_W-1:0] req_addr_q;
    l1d_geom_pkg::line_u             req_wdata_q;
    logic                            resp_ready_q;
    l1d_geom_pkg::line_u             fill_line_q;
    logic                            done_q;
    logic                            req_fire;
    logic                            resp_fire;

    assign req_fire  = req_valid_q && mem_req_ready_i;
    assign resp_fire = resp_ready_q && mem_resp_valid_i;

    assign mem_req_valid_o  = req_valid_q;
    assign mem_req_write_o  = req_write_q;
    assign mem_req_addr_o   = req_addr_q;
    assign mem_req_wdata_o  = req_wdata_q;
    assign mem_resp_ready_o = resp_ready_q;
    assign fill_line_o      = fill_line_q;
    assign done_o           = done_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_valid_q  <= 1'b0;
            resp_ready_q <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                req_valid_q <= 1'b1;
            end else if (req_fire) begin
                req_valid_q <= 1'b0;
                // Write-backs end at acceptance, reads wait for their line
                done_q       <= req_write_q;
                resp_ready_q <= !req_write_q;
            end
            if (resp_fire) begin
                resp_ready_q <= 1'b0;
                done_q       <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            req_write_q <= write_i;
            req_addr_q  <= {addr_i[l1d_geom_pkg::ADDR_W-1:l1d_geom_pkg::OFFSET_W],
                            {l1d_geom_pkg::OFFSET_W{1'b0}}};
            req_wdata_q <= line_i;
        end
        if (resp_fire) begin
            fill_line_q <= mem_resp_rdata_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_write_o)
            && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o));

endmodule

`default_nettype wire

// ==== source/l1d_data_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1d_data_store (
    input  wire logic                                  clk_i,
    input  wire logic [l1d_geom_pkg::INDEX_W-1:0]      index_i,
    input  wire logic [l1d_geom_pkg::WORD_SEL_W-1:0]   word_sel_i,
    input  wire logic [l1d_policy_pkg::WAY_W-1:0]      way_i,
    input  wire logic                                  word_we_i,
    input  wire logic [l1d_geom_pkg::DATA_W-1:0]       wdata_i,
    input  wire logic                                  line_we_i,
    input  wire l1d_geom_pkg::line_u                   line_i,
    output logic [l1d_geom_pkg::DATA_W-1:0]            rd_word_o,
    output l1d_geom_pkg::line_u                        line_o
);

    l1d_geom_pkg::line_u lines_q [l1d_policy_pkg::SETS][l1d_policy_pkg::WAYS];
    l1d_geom_pkg::line_u cur_line;

    assign cur_line    = lines_q[index_i][way_i];
    assign rd_word_o   = cur_line.words[word_sel_i];
    assign line_o.flat = cur_line.flat;

    // A refill replaces the whole line; word writes only touch one lane
    always_ff @(posedge clk_i) begin
        if (line_we_i) begin
            lines_q[index_i][way_i].flat <= line_i.flat;
        end else if (word_we_i) begin
            lines_q[index_i][way_i].words[word_sel_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/l1d_tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1d_tag_store (
    input  wire logic                                clk_i,
    input  wire logic                                rstn_i,
    input  wire logic [l1d_geom_pkg::ADDR_W-1:0]     lookup_addr_i,
    input  wire logic                                fill_i,
    input  wire logic [l1d_policy_pkg::WAY_W-1:0]    fill_way_i,
    input  wire logic                                mark_dirty_i,
    input  wire logic [l1d_policy_pkg::WAY_W-1:0]    dirty_way_i,
    output logic                                     hit_o,
    output logic [l1d_policy_pkg::WAY_W-1:0]         hit_way_o,
    output logic [l1d_policy_pkg::WAY_W-1:0]         victim_way_o,
    output logic                                     victim_dirty_o,
    output logic [l1d_geom_pkg::TAG_W-1:0]           victim_tag_o
);

    logic [l1d_policy_pkg::WAYS-1:0]  valid_q [l1d_policy_pkg::SETS];
    logic [l1d_policy_pkg::WAYS-1:0]  dirty_q [l1d_policy_pkg::SETS];
    logic [l1d_geom_pkg::TAG_W-1:0]   tag_q   [l1d_policy_pkg::SETS][l1d_policy_pkg::WAYS];
    logic [l1d_policy_pkg::WAY_W-1:0] rr_q;
    logic [l1d_policy_pkg::WAYS-1:0]  hit_vec;
    logic [l1d_geom_pkg::INDEX_W-1:0] index;
    logic [l1d_geom_pkg::TAG_W-1:0]   tag;

    assign index = lookup_addr_i[l1d_geom_pkg::INDEX_LSB +: l1d_geom_pkg::INDEX_W];
    assign tag   = lookup_addr_i[l1d_geom_pkg::TAG_LSB +: l1d_geom_pkg::TAG_W];

    // Downward scan so the lowest invalid way wins
    always_comb begin
        hit_way_o    = '0;
        victim_way_o = rr_q;
        for (int w = l1d_policy_pkg::WAYS - 1; w >= 0; w--) begin
            hit_vec[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (hit_vec[w]) begin
                hit_way_o = l1d_policy_pkg::WAY_W'(w);
            end
            if (!valid_q[index][w]) begin
                victim_way_o = l1d_policy_pkg::WAY_W'(w);
            end
        end
        hit_o = |hit_vec;
    end

    assign victim_dirty_o = valid_q[index][victim_way_o] && dirty_q[index][victim_way_o];
    assign victim_tag_o   = tag_q[index][victim_way_o];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < l1d_policy_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rr_q <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index][fill_way_i] <= 1'b1;
                dirty_q[index][fill_way_i] <= 1'b0;
                rr_q <= rr_q + l1d_policy_pkg::WAY_W'(1);
            end
            if (mark_dirty_i) begin
                dirty_q[index][dirty_way_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[index][fill_way_i] <= tag;
        end
    end

    // Fills only follow a miss, so a tag never sits in two ways of a set
    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== source/l1d_policy_pkg.sv ====
`default_nettype none

package l1d_policy_pkg;

    localparam int WAYS  = 2;
    localparam int WAY_W = 1;
    localparam int SETS  = 1 << l1d_geom_pkg::INDEX_W;

    // Controller states
    localparam int ST_W = 3;

    localparam logic [ST_W-1:0] ST_IDLE      = 3'd0;
    localparam logic [ST_W-1:0] ST_LOOKUP    = 3'd1;
    localparam logic [ST_W-1:0] ST_RESPOND   = 3'd2;
    localparam logic [ST_W-1:0] ST_EVICT     = 3'd3;
    localparam logic [ST_W-1:0] ST_FILL      = 3'd4;
    localparam logic [ST_W-1:0] ST_FILL_WAIT = 3'd5;

endpackage

`default_nettype wire

// ==== source/l1d_geom_pkg.sv ====
`default_nettype none

package l1d_geom_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = DATA_W * WORDS_PER_LINE;

    // Byte address split into tag, index, word select and byte
    localparam int OFFSET_W     = 4;
    localparam int WORD_SEL_LSB = 2;
    localparam int WORD_SEL_W   = OFFSET_W - WORD_SEL_LSB;
    localparam int INDEX_LSB    = 4;
    localparam int INDEX_W      = 3;
    localparam int TAG_LSB      = 7;
    localparam int TAG_W        = 25;

    // Memory bus sees one flat line, the processor side sees words
    typedef union packed {
        logic [LINE_W-1:0]                     flat;
        logic [WORDS_PER_LINE-1:0][DATA_W-1:0] words;
    } line_u;

endpackage

`default_nettype wire
